// ==== design/amu_ctrl.sv ====
// AMU controller that accepts requests, drives memory and monitor and holds the response
`timescale 1ns/1ps
`default_nettype none
`include "amu_config.svh"

module amu_ctrl (
	input  wire                   clk,
	input  wire                   rst_n,
	// Request channel
	input  wire                   req_valid,
	output logic                  req_ready,
	input  wire amu_pkg::amu_op_t req_op,
	input  wire amu_pkg::word_t   req_addr,
	input  wire amu_pkg::word_t   req_wdata,
	// Response channel
	output logic                  resp_valid,
	input  wire                   resp_ready,
	output amu_pkg::word_t        resp_data,
	// Memory side
	output logic                  ram_en,
	output logic                  ram_we,
	output amu_pkg::widx_t        ram_idx,
	output amu_pkg::word_t        ram_wdata,
	input  wire amu_pkg::word_t   ram_rdata,
	// Monitor side
	output logic                  mon_update,
	output logic                  mon_lr,
	output logic                  mon_sc,
	output logic                  mon_wr,
	output amu_pkg::word_t        mon_addr,
	input  wire                   mon_success
);

	import amu_pkg::*;

	localparam int IDX_W = $clog2(`AMU_MEM_WORDS);

	ctrl_state_t state;
	ctrl_state_t state_next;
	amu_op_t     op_q;
	word_t       addr_q;
	word_t       wdata_q;
	logic        sc_fail_q;  // Outcome of the last SC
	logic        is_st;
	logic        in_access;

	// ~~~~~~~~~~~~~~~~~~~~
	// State machine
	// ~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		state_next = state;
		case (state)
			IDLE:    if (req_valid) state_next = ACCESS;
			ACCESS:  state_next = RESP;   // Single cycle
			RESP:    if (resp_ready) state_next = IDLE;
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Request payload, loaded on the accept edge
	always_ff @(posedge clk) begin
		if (req_valid && req_ready) begin
			op_q    <= req_op;
			addr_q  <= req_addr;
			wdata_q <= req_wdata;
		end
		if (in_access && mon_sc) begin
			sc_fail_q <= ~mon_success;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Memory and monitor
	// ~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		in_access  = state == ACCESS;
		is_st      = op_q == `AMU_OP_ST;
		mon_lr     = op_q == `AMU_OP_LR;
		mon_sc     = op_q == `AMU_OP_SC;
		mon_update = in_access;
		mon_addr   = addr_q;
		ram_en     = in_access;
		ram_we     = in_access & (is_st | (mon_sc & mon_success));  // SC gated by monitor
		mon_wr     = ram_we;     // A successful SC counts as a local write
		ram_idx    = addr_q[IDX_W+1:2];
		ram_wdata  = wdata_q;
	end

	// Response is stable in RESP since memory and op are idle
	always_comb begin
		req_ready  = state == IDLE;
		resp_valid = state == RESP;
		case (op_q)
			`AMU_OP_ST: resp_data = '0;
			`AMU_OP_SC: resp_data = word_t'(sc_fail_q);  // 0 on success and 1 on failure
			default:    resp_data = ram_rdata;           // LD and LR
		endcase
	end

endmodule : amu_ctrl

`default_nettype wire

// ==== design/amu_pkg.sv ====
// AMU package with vector types for words, indices, opcodes and controller state
`default_nettype none
`include "amu_config.svh"

package amu_pkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// Datapath vectors
	// ~~~~~~~~~~~~~~~~~~~~
	typedef logic [`AMU_XLEN-1:0] word_t;                 // Data or address word
	typedef logic [$clog2(`AMU_MEM_WORDS)-1:0] widx_t;    // Word index into memory

	// Request operation, encoded as the AMU_OP_* macros
	typedef logic [1:0] amu_op_t;

	// ~~~~~~~~~~~~~~~~~~~~
	// Controller FSM
	// ~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [1:0] {
		IDLE   = 2'd0,  // Waiting for a request
		ACCESS = 2'd1,  // Memory and monitor busy for one cycle
		RESP   = 2'd2   // Response offered to the core
	} ctrl_state_t;

endpackage : amu_pkg

`default_nettype wire

// ==== design/amu_top.sv ====
// AMU top level joining the controller with the local word memory and the exclusive monitor
`timescale 1ns/1ps
`default_nettype none

module amu_top (
	input  wire                   clk,
	input  wire                   rst_n,
	// Request channel
	input  wire                   req_valid,
	output logic                  req_ready,
	input  wire amu_pkg::amu_op_t req_op,
	input  wire amu_pkg::word_t   req_addr,
	input  wire amu_pkg::word_t   req_wdata,
	// Response channel
	output logic                  resp_valid,
	input  wire                   resp_ready,
	output amu_pkg::word_t        resp_data,
	// Snoop from other harts
	input  wire                   snoop_valid,
	input  wire amu_pkg::word_t   snoop_addr
);

	import amu_pkg::*;

	// ~~~~~~~~~~~~~~~~~~~~
	// Internal nets
	// ~~~~~~~~~~~~~~~~~~~~
	logic  ram_en;
	logic  ram_we;
	widx_t ram_idx;
	word_t ram_wdata;
	word_t ram_rdata;
	logic  mon_update;
	logic  mon_lr;
	logic  mon_sc;
	logic  mon_wr;
	word_t mon_addr;
	logic  mon_success;

	amu_ctrl u_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_valid   (req_valid),
		.req_ready   (req_ready),
		.req_op      (req_op),
		.req_addr    (req_addr),
		.req_wdata   (req_wdata),
		.resp_valid  (resp_valid),
		.resp_ready  (resp_ready),
		.resp_data   (resp_data),
		.ram_en      (ram_en),
		.ram_we      (ram_we),
		.ram_idx     (ram_idx),
		.ram_wdata   (ram_wdata),
		.ram_rdata   (ram_rdata),
		.mon_update  (mon_update),
		.mon_lr      (mon_lr),
		.mon_sc      (mon_sc),
		.mon_wr      (mon_wr),
		.mon_addr    (mon_addr),
		.mon_success (mon_success)
	);

	data_ram u_ram (
		.clk   (clk),
		.en    (ram_en),
		.we    (ram_we),
		.idx   (ram_idx),
		.wdata (ram_wdata),
		.rdata (ram_rdata)
	);

	// Snoops bypass the controller
	reservation_stack u_mon (
		.clk         (clk),
		.rst_n       (rst_n),
		.update      (mon_update),
		.lr          (mon_lr),
		.sc          (mon_sc),
		.wr          (mon_wr),
		.addr        (mon_addr),
		.snoop_valid (snoop_valid),
		.snoop_addr  (snoop_addr),
		.success     (mon_success)
	);

endmodule : amu_top

`default_nettype wire

// ==== design/data_ram.sv ====
// Local word memory with synchronous write and registered read
`timescale 1ns/1ps
`default_nettype none
`include "amu_config.svh"

module data_ram (
	input  wire                 clk,
	input  wire                 en,     // Access strobe
	input  wire                 we,     // Write enable, only with en
	input  wire amu_pkg::widx_t idx,
	input  wire amu_pkg::word_t wdata,
	output amu_pkg::word_t      rdata
);

	import amu_pkg::*;

	// ~~~~~~~~~~~~~~~~~~~~
	// Storage array
	// ~~~~~~~~~~~~~~~~~~~~
	word_t mem [`AMU_MEM_WORDS];

	// Read returns the old contents on a write cycle
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[idx] <= wdata;
			end
			rdata <= mem[idx];  // Held while en is low
		end
	end

endmodule : data_ram

`default_nettype wire

// ==== design/reservation_stack.sv ====
// Exclusive monitor keeping a stack of LR reservations and judging SC success
`timescale 1ns/1ps
`default_nettype none
`include "amu_config.svh"

module reservation_stack (
	input  wire               clk,
	input  wire               rst_n,
	input  wire               update,       // One-cycle pulse per request
	input  wire               lr,
	input  wire               sc,
	input  wire               wr,           // Local write including a successful SC
	input  wire amu_pkg::word_t addr,
	input  wire               snoop_valid,  // Write by another hart
	input  wire amu_pkg::word_t snoop_addr,
	output logic              success
);

	import amu_pkg::*;

	typedef logic [$clog2(`AMU_RES_DEPTH)-1:0] rptr_t;

	word_t                   ent_addr [`AMU_RES_DEPTH];
	logic [`AMU_RES_DEPTH-1:0] ent_valid;
	rptr_t                   ptr;        // Newest entry
	rptr_t                   push_slot;
	word_t                   top_addr;
	logic                    top_valid;
	logic                    push;
	logic                    pop;
	logic                    local_hit;
	logic                    snoop_hit;
	logic                    clear_top;

	// ~~~~~~~~~~~~~~~~~~~~
	// Top-of-stack compare
	// ~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		top_addr  = ent_addr[ptr];
		top_valid = ent_valid[ptr];
		push      = update & lr;
		pop       = update & sc;
		push_slot = ptr + rptr_t'(1);
		// Byte offset ignored in the word compare
		local_hit = addr[`AMU_XLEN-1:2] == top_addr[`AMU_XLEN-1:2];
		snoop_hit = snoop_addr[`AMU_XLEN-1:2] == top_addr[`AMU_XLEN-1:2];
		clear_top = (update & wr & local_hit) | (snoop_valid & snoop_hit);
		success   = sc & local_hit & top_valid;
	end

	// Pointer wraps freely without an overflow check
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ptr <= '1;  // Empty stack sits at the last entry
		end else if (push) begin
			ptr <= push_slot;
		end else if (pop) begin
			ptr <= ptr - rptr_t'(1);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Entry storage
	// ~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `AMU_RES_DEPTH; i++) begin
				ent_addr[i]  <= '0;
				ent_valid[i] <= 1'b0;
			end
		end else begin
			for (int i = 0; i < `AMU_RES_DEPTH; i++) begin
				if (push && rptr_t'(i) == push_slot) begin
					ent_addr[i]  <= addr;
					ent_valid[i] <= 1'b1;
				end else if (clear_top && rptr_t'(i) == ptr) begin
					ent_valid[i] <= 1'b0;  // Reserved word was written
				end
			end
		end
	end

endmodule : reservation_stack

`default_nettype wire

// ==== files.f ====
+incdir+include
design/amu_pkg.sv
design/reservation_stack.sv
design/data_ram.sv
design/amu_ctrl.sv
design/amu_top.sv
sim/amu_tb.sv

// ==== include/amu_config.svh ====
// AMU configuration macros for data width, memory size, monitor depth and opcodes
`ifndef AMU_CONFIG_SVH
`define AMU_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Widths and sizes
// ~~~~~~~~~~~~~~~~~~~~
`define AMU_XLEN      32   // Data and address width
`define AMU_MEM_WORDS 256  // Words in the local memory
`define AMU_RES_DEPTH 4    // Reservation stack entries (power of two)

// ~~~~~~~~~~~~~~~~~~~~
// Operation codes
// ~~~~~~~~~~~~~~~~~~~~
`define AMU_OP_LD 2'd0  // Plain load
`define AMU_OP_ST 2'd1  // Plain store
`define AMU_OP_LR 2'd2  // Load-reserved
`define AMU_OP_SC 2'd3  // Store-conditional

// All accesses are aligned words, so the two low address bits are dropped

`endif

// ==== run.sh ====
#!/bin/sh
# Build the AMU testbench with Verilator and run it
# The exit status is nonzero when the build fails or the testbench stops with $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module amu_tb -f files.f -o amu_sim \
	&& ./obj_dir/amu_sim \
	|| { echo "AMU simulation did not complete cleanly"; exit 1; }

exit 0

// ==== sim/amu_tb.sv ====
// AMU testbench with directed and random requests checked against a reference model
`timescale 1ns/1ps
`default_nettype none
`include "amu_config.svh"

module amu_tb;

	import amu_pkg::*;

	localparam int MAX_CYCLES = 4000;  // About 300 requests at up to 10 cycles each
	localparam int RAND_REQS  = 250;
	localparam int RES_PTR_W  = $clog2(`AMU_RES_DEPTH);

	logic    clk;
	logic    rst_n;
	logic    req_valid;
	logic    req_ready;
	amu_op_t req_op;
	word_t   req_addr;
	word_t   req_wdata;
	logic    resp_valid;
	logic    resp_ready;
	word_t   resp_data;
	logic    snoop_valid;
	word_t   snoop_addr;

	// ~~~~~~~~~~~~~~~~~~~~
	// Reference model state
	// ~~~~~~~~~~~~~~~~~~~~
	word_t   shadow [`AMU_MEM_WORDS];
	word_t   res_addr [`AMU_RES_DEPTH];
	logic    res_valid [`AMU_RES_DEPTH];
	logic [RES_PTR_W-1:0] res_top;  // Wraps like the monitor pointer
	word_t   exp_q [$];

	logic    pending;    // Request accepted and response not yet taken
	int      age;        // Edges since the accept edge
	logic    held;
	word_t   held_data;
	word_t   exp_data;
	int      cycle_cnt;

	integer  seed;
	logic    rand_ready;
	int      stall;      // Cycles to hold resp_ready low once valid
	word_t   rnd;
	amu_op_t rnd_op;
	word_t   rnd_addr;
	word_t   last_lr;

	amu_top u_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_valid   (req_valid),
		.req_ready   (req_ready),
		.req_op      (req_op),
		.req_addr    (req_addr),
		.req_wdata   (req_wdata),
		.resp_valid  (resp_valid),
		.resp_ready  (resp_ready),
		.resp_data   (resp_data),
		.snoop_valid (snoop_valid),
		.snoop_addr  (snoop_addr)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	function automatic word_t word_at(input int i);
		return word_t'(i) << 2;
	endfunction

	// Expected response from the memory and reservation rules
	function automatic word_t model_request(input amu_op_t op, input word_t addr,
			input word_t wdata);
		widx_t idx;
		logic  top_hit;
		word_t result;
		idx     = addr[$clog2(`AMU_MEM_WORDS)+1:2];
		top_hit = addr[`AMU_XLEN-1:2] == res_addr[res_top][`AMU_XLEN-1:2];
		result  = '0;
		case (op)
			`AMU_OP_LD: result = shadow[idx];
			`AMU_OP_ST: begin
				shadow[idx] = wdata;
				if (top_hit)
					res_valid[res_top] = 1'b0;  // Own store breaks the reservation
			end
			`AMU_OP_LR: begin
				result             = shadow[idx];
				res_top            = res_top + RES_PTR_W'(1);
				res_addr[res_top]  = addr;
				res_valid[res_top] = 1'b1;
			end
			default: begin  // SC pops whether it succeeds or not
				if (top_hit && res_valid[res_top]) begin
					shadow[idx]        = wdata;
					res_valid[res_top] = 1'b0;
				end else begin
					result = word_t'(1);
				end
				res_top = res_top - RES_PTR_W'(1);
			end
		endcase
		return result;
	endfunction

	function automatic void model_snoop(input word_t addr);
		if (addr[`AMU_XLEN-1:2] == res_addr[res_top][`AMU_XLEN-1:2])
			res_valid[res_top] = 1'b0;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~
	// Bus drivers
	// ~~~~~~~~~~~~~~~~~~~~
	task automatic issue_request(input amu_op_t op, input word_t addr, input word_t wdata);
		word_t r;
		logic  done;
		exp_q.push_back(model_request(op, addr, wdata));
		@(negedge clk);
		req_valid = 1'b1;
		req_op    = op;
		req_addr  = addr;
		req_wdata = wdata;
		while (!req_ready)
			@(negedge clk);
		@(negedge clk);
		req_valid = 1'b0;
		done      = 1'b0;
		while (!done) begin
			@(negedge clk);
			r = $random(seed);
			if (resp_valid && stall > 0) begin
				resp_ready = 1'b0;
				stall      = stall - 1;
			end else if (rand_ready) begin
				resp_ready = r[0];
			end else begin
				resp_ready = 1'b1;
			end
			done = resp_valid & resp_ready;  // Handshake on the next rising edge
		end
	endtask

	task automatic send_snoop(input word_t addr);
		model_snoop(addr);
		@(negedge clk);
		snoop_valid = 1'b1;
		snoop_addr  = addr;
		@(negedge clk);
		snoop_valid = 1'b0;
	endtask

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES)
			report_failure($sformatf("Timeout: test still running after %0d cycles",
				MAX_CYCLES));
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Protocol and data checks
	// ~~~~~~~~~~~~~~~~~~~~
	always @(posedge clk) begin
		if (rst_n) begin
			if (!pending) begin
				assert (req_ready && !resp_valid)
					else report_failure($sformatf("Idle unit at %0t has req_ready low or resp_valid high",
						$time));
			end else begin
				age = age + 1;
				assert (!req_ready)
					else report_failure($sformatf("req_ready high at %0t with a request in flight",
						$time));
				assert (resp_valid == (age >= 2))
					else report_failure($sformatf("Mismatch at %0t: resp_valid = %b, expected %b",
						$time, resp_valid, age >= 2));
			end
			if (held) begin
				assert (resp_data == held_data)
					else report_failure($sformatf("Mismatch at %0t: resp_data = %h, expected %h",
						$time, resp_data, held_data));
			end
			if (resp_valid && resp_ready) begin
				exp_data = exp_q.pop_front();
				assert (resp_data == exp_data)
					else report_failure($sformatf("Mismatch at %0t: resp_data = %h, expected %h",
						$time, resp_data, exp_data));
				pending = 1'b0;
			end
			held      = resp_valid & ~resp_ready;
			held_data = resp_data;
			if (req_valid && req_ready) begin
				pending = 1'b1;
				age     = 0;
			end
		end
	end

	initial begin
		seed        = 8559;
		rst_n       = 1'b0;
		req_valid   = 1'b0;
		req_op      = `AMU_OP_LD;
		req_addr    = '0;
		req_wdata   = '0;
		resp_ready  = 1'b1;
		snoop_valid = 1'b0;
		snoop_addr  = '0;
		rand_ready  = 1'b0;
		stall       = 0;
		last_lr     = '0;
		pending     = 1'b0;
		age         = 0;
		held        = 1'b0;
		held_data   = '0;
		cycle_cnt   = 0;
		res_top     = '1;  // Empty stack at the last entry
		for (int i = 0; i < `AMU_RES_DEPTH; i++) begin
			res_addr[i]  = '0;
			res_valid[i] = 1'b0;
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		repeat (3) @(negedge clk);

		// Preload the 16 words that are read later
		for (int i = 0; i < 16; i++)
			issue_request(`AMU_OP_ST, word_at(i), 32'h5A00_0000 ^ word_at(i));

		issue_request(`AMU_OP_ST, word_at(4), 32'h1234_5678);
		issue_request(`AMU_OP_LD, word_at(4), '0);
		// LR/SC pair and pairs broken by a local store or a snoop
		issue_request(`AMU_OP_LR, word_at(5), '0);
		issue_request(`AMU_OP_SC, word_at(5), 32'hCAFE_0001);
		issue_request(`AMU_OP_LD, word_at(5), '0);
		issue_request(`AMU_OP_LR, word_at(6), '0);
		issue_request(`AMU_OP_ST, word_at(6), 32'h0BAD_0006);
		issue_request(`AMU_OP_SC, word_at(6), 32'hCAFE_0002);
		issue_request(`AMU_OP_LD, word_at(6), '0);
		issue_request(`AMU_OP_LR, word_at(7), '0);
		send_snoop(word_at(7));
		issue_request(`AMU_OP_SC, word_at(7), 32'hCAFE_0003);
		issue_request(`AMU_OP_LD, word_at(7), '0);
		// Nested pairs with a snoop before the inner LR
		issue_request(`AMU_OP_LR, word_at(8), '0);
		send_snoop(word_at(9));
		issue_request(`AMU_OP_LR, word_at(9), '0);
		issue_request(`AMU_OP_SC, word_at(9), 32'hBEEF_0009);
		issue_request(`AMU_OP_SC, word_at(8), 32'hBEEF_0008);
		issue_request(`AMU_OP_LD, word_at(9), '0);
		issue_request(`AMU_OP_LD, word_at(8), '0);
		// Back-pressure on the response
		stall = 6;
		issue_request(`AMU_OP_ST, word_at(10), 32'h00C0_FFEE);
		stall = 5;
		issue_request(`AMU_OP_LD, word_at(10), '0);

		rand_ready = 1'b1;
		for (int n = 0; n < RAND_REQS; n++) begin
			rnd = $random(seed);
			if (rnd[4:2] == 3'd0)
				send_snoop(word_at(int'(rnd[11:8])));
			rnd_op   = rnd[1:0];
			rnd_addr = word_at(int'(rnd[15:12]));
			if (rnd_op == `AMU_OP_SC && rnd[16])
				rnd_addr = last_lr;  // Aim at a live reservation half the time
			if (rnd_op == `AMU_OP_LR)
				last_lr = rnd_addr;
			issue_request(rnd_op, rnd_addr, $random(seed));
		end

		repeat (4) @(negedge clk);
		$display("Result: PASSED");
		$finish;
	end

endmodule : amu_tb

`default_nettype wire
